// ==== hdl/dbg_pkg.sv ====
// ----------------------------------------
// Debug unit shared types and constants
// Host register map is 6-bit, unused
// addresses read as zero
// Register layouts are 8 bits wide and are
// zero-extended on the 16-bit host port
// ----------------------------------------
`default_nettype none

package dbg_pkg;

  typedef logic [15:0] dbg_word_t;          // Host and memory data word
  typedef logic [5:0]  dbg_addr_t;          // Debug register address

  // Register map
  localparam dbg_addr_t ADDR_CPU_ID_LO = 6'h00;
  localparam dbg_addr_t ADDR_CPU_ID_HI = 6'h01;
  localparam dbg_addr_t ADDR_CPU_CTL   = 6'h02;
  localparam dbg_addr_t ADDR_CPU_STAT  = 6'h03;
  localparam dbg_addr_t ADDR_MEM_CTL   = 6'h04;
  localparam dbg_addr_t ADDR_MEM_ADDR  = 6'h05;
  localparam dbg_addr_t ADDR_MEM_DATA  = 6'h06;

  localparam dbg_word_t SWBRK_OP_DEFAULT = 16'h4343;  // Software break opcode
  localparam logic      RST_BRK_DEFAULT  = 1'b0;      // Halt after reset off

  // Host request, strobes are single cycle
  typedef struct packed {
    dbg_addr_t addr;
    dbg_word_t din;
    logic      wr;
    logic      rd;
  } dbg_req_t;

  // One write select per writable register
  typedef struct packed {
    logic cpu_ctl;
    logic cpu_stat;
    logic mem_ctl;
    logic mem_addr;
    logic mem_data;
  } reg_sel_t;

  // ----------------------------------------
  // Register layouts, bit 7 first
  // ----------------------------------------
  typedef struct packed {
    logic rsvd;
    logic cpu_rst;
    logic rst_brk_en;
    logic frz_brk_en;
    logic sw_brk_en;
    logic istep;                            // Command, reads as zero
    logic run;                              // Command, reads as zero
    logic halt;                             // Command, reads as zero
  } cpu_ctl_t;

  typedef struct packed {
    logic [3:0] rsvd_hi;                    // Former breakpoint pending bits
    logic       swbrk_pnd;
    logic       puc_pnd;
    logic       rsvd;
    logic       halt_run;
  } cpu_stat_t;

  typedef struct packed {
    logic [3:0] rsvd;
    logic       bw;                         // 1 = byte access
    logic       reg_acc;                    // 1 = CPU register, 0 = memory
    logic       wr;                         // 1 = write
    logic       start;
  } mem_ctl_t;

  // Bus toward CPU memory and register file
  typedef struct packed {
    dbg_word_t  addr;
    dbg_word_t  dout;
    logic       mem_en;
    logic [1:0] mem_wr;                     // Byte lane write enables
    logic       reg_wr;
  } mem_bus_t;

  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_SET_BRK,                            // Waiting for the CPU to halt
    ACC_ACCESS_BRK,                         // Access, then resume the CPU
    ACC_ACCESS                              // Access, CPU was already halted
  } acc_state_t;

endpackage

`default_nettype wire

// ==== hdl/dbg_reg_port.sv ====
// ----------------------------------------
// Host register decode and read mux
// Writes land on the next edge
// Read data valid while addr is held
// rd_rdy follows rd by one cycle
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dbg_reg_port import dbg_pkg::*; (
  input  wire             dbg_clk,
  input  wire             dbg_rst,
  input  wire dbg_req_t   dbg_req,
  input  wire [31:0]      cpu_id,
  input  wire cpu_ctl_t   cpu_ctl_rd,
  input  wire cpu_stat_t  cpu_stat_rd,
  input  wire mem_ctl_t   mem_ctl_rd,
  input  wire dbg_word_t  mem_addr_rd,
  input  wire dbg_word_t  mem_data_rd,
  output reg_sel_t        reg_sel,
  output dbg_word_t       dbg_dout,
  output logic            dbg_rd_rdy
);

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  logic hit_id_lo;
  logic hit_id_hi;
  logic hit_cpu_ctl;
  logic hit_cpu_stat;
  logic hit_mem_ctl;
  logic hit_mem_addr;
  logic hit_mem_data;

  assign hit_id_lo    = (dbg_req.addr == ADDR_CPU_ID_LO);
  assign hit_id_hi    = (dbg_req.addr == ADDR_CPU_ID_HI);
  assign hit_cpu_ctl  = (dbg_req.addr == ADDR_CPU_CTL);
  assign hit_cpu_stat = (dbg_req.addr == ADDR_CPU_STAT);
  assign hit_mem_ctl  = (dbg_req.addr == ADDR_MEM_CTL);
  assign hit_mem_addr = (dbg_req.addr == ADDR_MEM_ADDR);
  assign hit_mem_data = (dbg_req.addr == ADDR_MEM_DATA);

  // Write selects, identity registers are read only
  always_comb begin
    reg_sel          = '0;
    reg_sel.cpu_ctl  = hit_cpu_ctl  & dbg_req.wr;
    reg_sel.cpu_stat = hit_cpu_stat & dbg_req.wr;
    reg_sel.mem_ctl  = hit_mem_ctl  & dbg_req.wr;
    reg_sel.mem_addr = hit_mem_addr & dbg_req.wr;
    reg_sel.mem_data = hit_mem_data & dbg_req.wr;
  end

  // ----------------------------------------
  // Read data, AND-OR mux
  // ----------------------------------------
  assign dbg_dout = ({16{hit_id_lo}}    & cpu_id[15:0])          |
                    ({16{hit_id_hi}}    & cpu_id[31:16])         |
                    ({16{hit_cpu_ctl}}  & {8'h00, cpu_ctl_rd})   |
                    ({16{hit_cpu_stat}} & {8'h00, cpu_stat_rd})  |
                    ({16{hit_mem_ctl}}  & {8'h00, mem_ctl_rd})   |
                    ({16{hit_mem_addr}} & mem_addr_rd)           |
                    ({16{hit_mem_data}} & mem_data_rd);         // Others read 0

  // Read ready pulse for the host
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_rd_rdy <= 1'b0;
    end else begin
      dbg_rd_rdy <= dbg_req.rd;
    end
  end

  // Only one register written per strobe
  a_sel_onehot: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    $onehot0(reg_sel));

endmodule

`default_nettype wire

// ==== hdl/dbg_cpu_ctl.sv ====
// ----------------------------------------
// CPU run control, CPU_CTL and CPU_STAT
// Halt/run/istep are commands, read as zero
// Sticky flags clear on write of zero
// Halt is combinational on the write cycle
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dbg_cpu_ctl import dbg_pkg::*; #(
  parameter dbg_word_t SWBRK_OP   = SWBRK_OP_DEFAULT,
  parameter logic      RST_BRK_EN = RST_BRK_DEFAULT
) (
  input  wire             dbg_clk,
  input  wire             dbg_rst,
  input  wire reg_sel_t   reg_sel,
  input  wire dbg_word_t  din,
  input  wire             dbg_halt_st,
  input  wire             dbg_en_s,
  input  wire             cpu_en_s,
  input  wire             puc_pnd_set,
  input  wire             decode_noirq,
  input  wire dbg_word_t  fe_mdb_in,
  input  wire             acc_halt,
  input  wire             acc_run,
  output cpu_ctl_t        cpu_ctl_rd,
  output cpu_stat_t       cpu_stat_rd,
  output logic            dbg_halt_cmd,
  output logic            dbg_freeze,
  output logic            dbg_cpu_reset
);

  // Only rst_brk_en differs from zero out of reset
  localparam cpu_ctl_t CTL_RST = '{
    rsvd:       1'b0,
    cpu_rst:    1'b0,
    rst_brk_en: RST_BRK_EN,
    frz_brk_en: 1'b0,
    sw_brk_en:  1'b0,
    istep:      1'b0,
    run:        1'b0,
    halt:       1'b0
  };

  cpu_ctl_t   din_ctl;                      // Host data seen as CPU_CTL
  cpu_stat_t  din_stat;                     // Host data seen as CPU_STAT
  cpu_ctl_t   ctl_q;
  logic       swbrk_pnd_q;
  logic       puc_pnd_q;
  logic       halt_cpu;
  logic       run_cpu;
  logic       istep;
  logic       halt_rst;
  logic       dbg_swbrk;
  logic [1:0] inc_step;
  logic       halt_flag;
  logic       halt_flag_set;
  logic       halt_flag_clr;

  assign din_ctl  = cpu_ctl_t'(din[7:0]);
  assign din_stat = cpu_stat_t'(din[7:0]);

  // ----------------------------------------
  // CPU_CTL configuration bits
  // ----------------------------------------
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      ctl_q <= CTL_RST;
    end else if (reg_sel.cpu_ctl) begin
      ctl_q.cpu_rst    <= din_ctl.cpu_rst;
      ctl_q.rst_brk_en <= din_ctl.rst_brk_en;
      ctl_q.frz_brk_en <= din_ctl.frz_brk_en;
      ctl_q.sw_brk_en  <= din_ctl.sw_brk_en;
    end
  end

  assign cpu_ctl_rd = ctl_q;                // Command bits stay zero

  // Commands only act when they change something
  assign halt_cpu = reg_sel.cpu_ctl & din_ctl.halt  & ~dbg_halt_st;
  assign run_cpu  = reg_sel.cpu_ctl & din_ctl.run   &  dbg_halt_st;
  assign istep    = reg_sel.cpu_ctl & din_ctl.istep &  dbg_halt_st;

  // ----------------------------------------
  // Break sources
  // ----------------------------------------
  assign halt_rst  = ctl_q.rst_brk_en & dbg_en_s & puc_pnd_set;
  assign dbg_swbrk = (fe_mdb_in == SWBRK_OP) & decode_noirq & ctl_q.sw_brk_en;

  // CPU_STAT sticky flags, set wins over clear
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      swbrk_pnd_q <= 1'b0;
      puc_pnd_q   <= 1'b0;
    end else begin
      swbrk_pnd_q <= dbg_swbrk   |
                     (swbrk_pnd_q & ~(reg_sel.cpu_stat & ~din_stat.swbrk_pnd));
      puc_pnd_q   <= puc_pnd_set |
                     (puc_pnd_q & ~(reg_sel.cpu_stat & ~din_stat.puc_pnd));
    end
  end

  always_comb begin
    cpu_stat_rd           = '0;
    cpu_stat_rd.swbrk_pnd = swbrk_pnd_q;
    cpu_stat_rd.puc_pnd   = puc_pnd_q;
    cpu_stat_rd.halt_run  = dbg_halt_st;    // Live CPU status
  end

  // ----------------------------------------
  // Run / halt / step
  // ----------------------------------------
  // Two cycle release window for one step
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      inc_step <= 2'b00;
    end else if (istep) begin
      inc_step <= 2'b11;
    end else begin
      inc_step <= {inc_step[0], 1'b0};
    end
  end

  assign halt_flag_set = halt_cpu | halt_rst | dbg_swbrk | acc_halt;
  assign halt_flag_clr = run_cpu | acc_run;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      halt_flag <= 1'b0;
    end else if (halt_flag_clr) begin
      halt_flag <= 1'b0;
    end else if (halt_flag_set) begin
      halt_flag <= 1'b1;
    end
  end

  // Set sources bypass the flag for same-cycle halt
  assign dbg_halt_cmd  = (halt_flag | halt_flag_set) & ~inc_step[1];
  assign dbg_freeze    = dbg_halt_st & (ctl_q.frz_brk_en | ~cpu_en_s);
  assign dbg_cpu_reset = ctl_q.cpu_rst;

  // Access resume only once the CPU really stopped
  a_run_halted: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    acc_run |-> dbg_halt_st);

endmodule

`default_nettype wire

// ==== hdl/dbg_mem_access.sv ====
// ----------------------------------------
// Single memory / CPU register access
// Running CPU is halted first, then resumed
// Byte mode lane follows address bit 0
// Starts during an access are dropped
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dbg_mem_access import dbg_pkg::*; (
  input  wire             dbg_clk,
  input  wire             dbg_rst,
  input  wire reg_sel_t   reg_sel,
  input  wire dbg_word_t  din,
  input  wire             dbg_halt_st,
  input  wire dbg_word_t  dbg_mem_din,
  input  wire dbg_word_t  dbg_reg_din,
  output mem_ctl_t        mem_ctl_rd,
  output dbg_word_t       mem_addr_rd,
  output dbg_word_t       mem_data_rd,
  output mem_bus_t        dbg_bus,
  output logic            acc_halt,
  output logic            acc_run
);

  mem_ctl_t   din_ctl;                      // Host data seen as MEM_CTL
  mem_ctl_t   ctl_q;
  logic       start_q;                      // Start pulse, one cycle late
  dbg_word_t  mem_addr;
  dbg_word_t  mem_data;
  dbg_word_t  mem_din_bw;
  acc_state_t state;
  acc_state_t state_nxt;
  logic       access;
  logic       mem_en;
  logic       reg_rd;
  logic       mem_rd;
  logic       mem_rd_dly;
  logic [1:0] wr_msk;

  assign din_ctl = mem_ctl_t'(din[7:0]);

  // ----------------------------------------
  // MEM_CTL / MEM_ADDR / MEM_DATA
  // ----------------------------------------
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      ctl_q   <= '0;
      start_q <= 1'b0;
    end else begin
      if (reg_sel.mem_ctl) begin
        ctl_q.bw      <= din_ctl.bw;
        ctl_q.reg_acc <= din_ctl.reg_acc;
        ctl_q.wr      <= din_ctl.wr;
      end
      start_q <= reg_sel.mem_ctl & din_ctl.start;
    end
  end

  assign mem_ctl_rd = ctl_q;                // Start reads back as zero

  // Extract the addressed byte on byte reads
  assign mem_din_bw = ~ctl_q.bw   ? dbg_mem_din                 :
                      mem_addr[0] ? {8'h00, dbg_mem_din[15:8]}  :
                                    {8'h00, dbg_mem_din[7:0]};

  always_ff @(posedge dbg_clk) begin
    if (reg_sel.mem_addr) begin
      mem_addr <= din;
    end
    if (reg_sel.mem_data) begin
      mem_data <= din;                      // Host write first
    end else if (reg_rd) begin
      mem_data <= dbg_reg_din;              // Register file answers at once
    end else if (mem_rd_dly) begin
      mem_data <= mem_din_bw;               // Memory answers a cycle late
    end
  end

  assign mem_addr_rd = mem_addr;
  assign mem_data_rd = mem_data;

  // ----------------------------------------
  // Access FSM
  // ----------------------------------------
  always_comb begin
    case (state)
      ACC_IDLE: begin
        if (!start_q)        state_nxt = ACC_IDLE;
        else if (dbg_halt_st) state_nxt = ACC_ACCESS;  // Already halted
        else                 state_nxt = ACC_SET_BRK;
      end
      ACC_SET_BRK:    state_nxt = dbg_halt_st ? ACC_ACCESS_BRK : ACC_SET_BRK;
      ACC_ACCESS_BRK: state_nxt = ACC_IDLE;
      ACC_ACCESS:     state_nxt = ACC_IDLE;
      default:        state_nxt = ACC_IDLE;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= ACC_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign acc_halt = (state == ACC_IDLE) & (state_nxt == ACC_SET_BRK);
  assign acc_run  = (state == ACC_ACCESS_BRK) & (state_nxt == ACC_IDLE);
  assign access   = (state == ACC_ACCESS) | (state == ACC_ACCESS_BRK);

  // ----------------------------------------
  // CPU side bus
  // ----------------------------------------
  assign mem_en = access & ~ctl_q.reg_acc;
  assign reg_rd = access &  ctl_q.reg_acc & ~ctl_q.wr;
  assign mem_rd = mem_en & ~ctl_q.wr;
  assign wr_msk = ~ctl_q.bw ? 2'b11 : (mem_addr[0] ? 2'b10 : 2'b01);

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      mem_rd_dly <= 1'b0;
    end else begin
      mem_rd_dly <= mem_rd;
    end
  end

  always_comb begin
    dbg_bus.addr   = mem_addr;
    // Byte data placed on the addressed lane
    dbg_bus.dout   = ~ctl_q.bw   ? mem_data               :
                     mem_addr[0] ? {mem_data[7:0], 8'h00} :
                                   {8'h00, mem_data[7:0]};
    dbg_bus.mem_en = mem_en;
    dbg_bus.mem_wr = {2{mem_en & ctl_q.wr}} & wr_msk;
    dbg_bus.reg_wr = access & ctl_q.reg_acc & ctl_q.wr;
  end

  // Memory and register file never driven in the same cycle
  a_bus_excl: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    !(dbg_bus.mem_en && dbg_bus.reg_wr));

endmodule

`default_nettype wire

// ==== hdl/dbg_unit.sv ====
// ----------------------------------------
// Debug unit top, parallel host register port
// Host strobes are one cycle, no back-pressure
// dbg_dout is combinational from addr
// Only one memory or register access at a time
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dbg_unit import dbg_pkg::*; #(
  parameter dbg_word_t SWBRK_OP   = SWBRK_OP_DEFAULT,
  parameter logic      RST_BRK_EN = RST_BRK_DEFAULT
) (
  input  wire             dbg_clk,
  input  wire             dbg_rst,
  // Host register port
  input  wire dbg_req_t   dbg_req,
  output dbg_word_t       dbg_dout,
  output logic            dbg_rd_rdy,
  // CPU state
  input  wire [31:0]      cpu_id,
  input  wire             cpu_en_s,
  input  wire             dbg_en_s,
  input  wire             dbg_halt_st,
  input  wire             puc_pnd_set,
  input  wire             decode_noirq,
  input  wire dbg_word_t  fe_mdb_in,
  // Read data from CPU
  input  wire dbg_word_t  dbg_mem_din,
  input  wire dbg_word_t  dbg_reg_din,
  // Toward CPU
  output mem_bus_t        dbg_bus,
  output logic            dbg_halt_cmd,
  output logic            dbg_freeze,
  output logic            dbg_cpu_reset
);

  reg_sel_t  reg_sel;                       // Write selects
  cpu_ctl_t  cpu_ctl_rd;
  cpu_stat_t cpu_stat_rd;
  mem_ctl_t  mem_ctl_rd;
  dbg_word_t mem_addr_rd;
  dbg_word_t mem_data_rd;
  logic      acc_halt;                      // Access asks for a halt
  logic      acc_run;                       // Access done, resume CPU

  dbg_reg_port reg_port_i (
    .dbg_clk     (dbg_clk),
    .dbg_rst     (dbg_rst),
    .dbg_req     (dbg_req),
    .cpu_id      (cpu_id),
    .cpu_ctl_rd  (cpu_ctl_rd),
    .cpu_stat_rd (cpu_stat_rd),
    .mem_ctl_rd  (mem_ctl_rd),
    .mem_addr_rd (mem_addr_rd),
    .mem_data_rd (mem_data_rd),
    .reg_sel     (reg_sel),
    .dbg_dout    (dbg_dout),
    .dbg_rd_rdy  (dbg_rd_rdy)
  );

  dbg_cpu_ctl #(
    .SWBRK_OP   (SWBRK_OP),
    .RST_BRK_EN (RST_BRK_EN)
  ) cpu_ctl_i (
    .dbg_clk       (dbg_clk),
    .dbg_rst       (dbg_rst),
    .reg_sel       (reg_sel),
    .din           (dbg_req.din),
    .dbg_halt_st   (dbg_halt_st),
    .dbg_en_s      (dbg_en_s),
    .cpu_en_s      (cpu_en_s),
    .puc_pnd_set   (puc_pnd_set),
    .decode_noirq  (decode_noirq),
    .fe_mdb_in     (fe_mdb_in),
    .acc_halt      (acc_halt),
    .acc_run       (acc_run),
    .cpu_ctl_rd    (cpu_ctl_rd),
    .cpu_stat_rd   (cpu_stat_rd),
    .dbg_halt_cmd  (dbg_halt_cmd),
    .dbg_freeze    (dbg_freeze),
    .dbg_cpu_reset (dbg_cpu_reset)
  );

  dbg_mem_access mem_access_i (
    .dbg_clk     (dbg_clk),
    .dbg_rst     (dbg_rst),
    .reg_sel     (reg_sel),
    .din         (dbg_req.din),
    .dbg_halt_st (dbg_halt_st),
    .dbg_mem_din (dbg_mem_din),
    .dbg_reg_din (dbg_reg_din),
    .mem_ctl_rd  (mem_ctl_rd),
    .mem_addr_rd (mem_addr_rd),
    .mem_data_rd (mem_data_rd),
    .dbg_bus     (dbg_bus),
    .acc_halt    (acc_halt),
    .acc_run     (acc_run)
  );

endmodule

`default_nettype wire

// ==== verification/dbg_tests.svh ====
// ----------------------------------------
// Directed tests, included in the testbench
// Each test leaves the CPU running
// ----------------------------------------
`ifndef DBG_TESTS_SVH
`define DBG_TESTS_SVH

// CPU_CTL word, rst_brk_en kept at its reset value
function automatic dbg_word_t ctl_value(input logic halt, input logic run,
                                        input logic istep, input logic sw_brk,
                                        input logic frz, input logic cpu_rst);
  cpu_ctl_t c;
  c            = '0;
  c.halt       = halt;
  c.run        = run;
  c.istep      = istep;
  c.sw_brk_en  = sw_brk;
  c.frz_brk_en = frz;
  c.cpu_rst    = cpu_rst;
  c.rst_brk_en = RST_BRK;
  return {8'h00, c};
endfunction

// Byte data goes to the lane picked by address bit 0
function automatic dbg_word_t lane_data(input logic bw, input dbg_word_t a,
                                        input dbg_word_t d);
  if (!bw) begin
    return d;
  end
  return a[0] ? {d[7:0], 8'h00} : {8'h00, d[7:0]};
endfunction

task automatic after_reset();
  dbg_word_t d;
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
  check_bit("dbg_bus.mem_en", dbg_bus.mem_en, 1'b0);
  check_bit("dbg_bus.mem_wr", |dbg_bus.mem_wr, 1'b0);
  check_bit("dbg_bus.reg_wr", dbg_bus.reg_wr, 1'b0);
  check_bit("dbg_freeze", dbg_freeze, 1'b0);
  check_bit("dbg_cpu_reset", dbg_cpu_reset, 1'b0);
  check_bit("dbg_rd_rdy", dbg_rd_rdy, 1'b0);
  host_read(ADDR_CPU_ID_LO, d);
  check_word("CPU_ID_LO", d, CPU_ID[15:0]);
  host_read(ADDR_CPU_ID_HI, d);
  check_word("CPU_ID_HI", d, CPU_ID[31:16]);
  host_read(ADDR_CPU_CTL, d);
  check_word("CPU_CTL", d, ctl_value(0, 0, 0, 0, 0, 0));
  host_read(ADDR_CPU_STAT, d);
  check_word("CPU_STAT", d, 16'h0000);
  host_read(6'h3f, d);                                 // Unmapped
  check_word("unmapped", d, 16'h0000);
endtask

task automatic halt_and_run();
  dbg_word_t d;
  write_strobe(ADDR_CPU_CTL, ctl_value(1, 0, 0, 0, 0, 0));
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);       // Same cycle as strobe
  end_strobe();
  wait_halt_st(1'b1);
  check_bit("dbg_freeze", dbg_freeze, 1'b0);           // Halted, freeze not enabled
  host_read(ADDR_CPU_STAT, d);
  check_word("CPU_STAT", d, 16'h0001);                 // halt_run only
  host_write(ADDR_CPU_CTL, ctl_value(0, 0, 0, 0, 1, 1));
  @(negedge dbg_clk);
  check_bit("dbg_freeze", dbg_freeze, 1'b1);
  check_bit("dbg_cpu_reset", dbg_cpu_reset, 1'b1);
  host_read(ADDR_CPU_CTL, d);
  check_word("CPU_CTL", d, ctl_value(0, 0, 0, 0, 1, 1));
  host_write(ADDR_CPU_CTL, ctl_value(0, 0, 0, 0, 1, 0));
  @(negedge dbg_clk);
  check_bit("dbg_cpu_reset", dbg_cpu_reset, 1'b0);
  write_strobe(ADDR_CPU_CTL, ctl_value(0, 1, 0, 0, 1, 0));
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);       // Still halted here
  end_strobe();
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
  wait_halt_st(1'b0);
  check_bit("dbg_freeze", dbg_freeze, 1'b0);           // Freeze follows halt status
endtask

task automatic single_step();
  host_write(ADDR_CPU_CTL, ctl_value(1, 0, 0, 0, 0, 0));
  wait_halt_st(1'b1);
  write_strobe(ADDR_CPU_CTL, ctl_value(0, 0, 1, 0, 0, 0));
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
  end_strobe();
  repeat (2) begin
    @(negedge dbg_clk);
    check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);     // Step window
  end
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
  wait_halt_st(1'b1);
  host_write(ADDR_CPU_CTL, ctl_value(0, 1, 0, 0, 0, 0));
  wait_halt_st(1'b0);
endtask

task automatic software_break();
  cpu_stat_t stat;
  dbg_word_t d;
  host_write(ADDR_CPU_CTL, ctl_value(0, 0, 0, 1, 0, 0));
  @(posedge dbg_clk);
  fe_mdb_in <= BRK_OP;                                 // Not a decode cycle yet
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b0);
  @(posedge dbg_clk);
  decode_noirq <= 1'b1;
  @(negedge dbg_clk);
  check_bit("dbg_halt_cmd", dbg_halt_cmd, 1'b1);
  @(posedge dbg_clk);
  decode_noirq <= 1'b0;
  fe_mdb_in    <= '0;
  wait_halt_st(1'b1);
  stat           = '0;
  stat.swbrk_pnd = 1'b1;
  stat.halt_run  = 1'b1;
  host_read(ADDR_CPU_STAT, d);
  check_word("CPU_STAT", d, {8'h00, stat});
  host_write(ADDR_CPU_STAT, 16'h0000);                 // Write zero clears
  stat.swbrk_pnd = 1'b0;
  host_read(ADDR_CPU_STAT, d);
  check_word("CPU_STAT", d, {8'h00, stat});
  host_write(ADDR_CPU_CTL, ctl_value(0, 1, 0, 0, 0, 0));
  wait_halt_st(1'b0);
endtask

// One memory access with the CPU already halted, fixed latency
task automatic access_halted(input mem_ctl_t ctl, input dbg_word_t a, input dbg_word_t d);
  mem_bus_t exp;
  mem_ctl_t go;
  exp        = '0;
  exp.addr   = a;
  exp.dout   = lane_data(ctl.bw, a, d);
  exp.mem_en = 1'b1;
  if (ctl.wr) begin
    exp.mem_wr = ~ctl.bw ? 2'b11 : (a[0] ? 2'b10 : 2'b01);
  end
  go       = ctl;
  go.start = 1'b1;
  host_write(ADDR_MEM_ADDR, a);
  host_write(ADDR_MEM_DATA, d);
  host_write(ADDR_MEM_CTL, {8'h00, go});
  @(negedge dbg_clk);
  check_bit("dbg_bus.mem_en", dbg_bus.mem_en, 1'b0);   // Start still registering
  @(negedge dbg_clk);
  check_bus("dbg_bus", dbg_bus, exp);
  @(negedge dbg_clk);
  check_bit("dbg_bus.mem_en", dbg_bus.mem_en, 1'b0);   // Exactly one cycle
endtask

task automatic access_while_halted();
  mem_ctl_t  ctl;
  dbg_word_t w_addr;
  dbg_word_t b_addr;
  dbg_word_t w_data;
  dbg_word_t b_data;
  dbg_word_t old;
  dbg_word_t d;
  host_write(ADDR_CPU_CTL, ctl_value(1, 0, 0, 0, 0, 0));
  wait_halt_st(1'b1);
  rand_bits(8, d);
  w_addr = {7'h00, d[7:0], 1'b0};                      // Even byte address
  rand_bits(8, d);
  b_addr = {7'h00, d[7:0], 1'b1};                      // Odd byte address
  rand_bits(16, w_data);
  rand_bits(16, b_data);
  ctl    = '0;
  ctl.wr = 1'b1;
  access_halted(ctl, w_addr, w_data);
  check_word("mem_model word", mem_model[w_addr[8:1]], w_data);
  old    = mem_model[b_addr[8:1]];
  ctl.bw = 1'b1;
  access_halted(ctl, b_addr, b_data);
  check_word("mem_model byte", mem_model[b_addr[8:1]], {b_data[7:0], old[7:0]});
  host_read(ADDR_MEM_CTL, d);
  check_word("MEM_CTL", d, {8'h00, ctl});              // Start reads as zero
  ctl = '0;
  access_halted(ctl, w_addr, ~w_data);                 // Preload differs
  host_read(ADDR_MEM_DATA, d);
  check_word("MEM_DATA word", d, w_data);
  ctl.bw = 1'b1;
  access_halted(ctl, b_addr, 16'h0000);
  host_read(ADDR_MEM_DATA, d);
  check_word("MEM_DATA byte", d, {8'h00, b_data[7:0]});
  host_write(ADDR_CPU_CTL, ctl_value(0, 1, 0, 0, 0, 0));
  wait_halt_st(1'b0);
endtask

// Follows an access started while running, until halt_cmd falls again
task automatic watch_running_access(output dbg_word_t n_wr);
  logic seen_halt;
  logic done;
  n_wr      = '0;
  seen_halt = 1'b0;
  done      = 1'b0;
  while (!done) begin
    @(negedge dbg_clk);
    check_bit("dbg_bus.mem_en", dbg_bus.mem_en, 1'b0);
    if (dbg_bus.reg_wr) begin
      check_bit("dbg_halt_st", dbg_halt_st, 1'b1);     // Only while stopped
      n_wr = n_wr + 1;
    end
    if (dbg_halt_cmd) begin
      seen_halt = 1'b1;
    end else if (seen_halt) begin
      done = 1'b1;
    end
  end
endtask

task automatic access_while_running();
  mem_ctl_t  ctl;
  dbg_word_t r_addr;
  dbg_word_t data;
  dbg_word_t n_wr;
  dbg_word_t d;
  rand_bits(4, r_addr);
  rand_bits(16, data);
  ctl         = '0;
  ctl.reg_acc = 1'b1;
  ctl.wr      = 1'b1;
  ctl.start   = 1'b1;
  host_write(ADDR_MEM_ADDR, r_addr);
  host_write(ADDR_MEM_DATA, data);
  host_write(ADDR_MEM_CTL, {8'h00, ctl});
  watch_running_access(n_wr);
  check_word("reg_wr pulses", n_wr, 16'd1);
  check_word("reg_model", reg_model[r_addr[3:0]], data);
  // Register read, no bus strobe expected
  wait_halt_st(1'b0);
  rand_bits(4, r_addr);
  ctl.wr = 1'b0;
  host_write(ADDR_MEM_ADDR, r_addr);
  host_write(ADDR_MEM_DATA, ~reg_model[r_addr[3:0]]);
  host_write(ADDR_MEM_CTL, {8'h00, ctl});
  watch_running_access(n_wr);
  check_word("reg_wr pulses", n_wr, 16'd0);
  host_read(ADDR_MEM_DATA, d);
  check_word("MEM_DATA reg", d, reg_model[r_addr[3:0]]);
endtask

`endif

// ==== verification/tb_dbg_unit.sv ====
// ----------------------------------------
// Testbench for the debug unit core
// Inputs change on the rising edge
// Outputs are sampled on the falling edge
// CPU model halts one cycle after the command
// Memory model is 256 words, byte addressed
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_unit import dbg_pkg::*;;

  localparam logic [31:0] CPU_ID      = 32'h1a2b_3c4d;
  localparam dbg_word_t   BRK_OP      = 16'h4343;
  localparam logic        RST_BRK     = 1'b1;          // Non-default on purpose
  localparam logic [31:0] SEED        = 32'h5674_6bb1;
  localparam int          CYCLE_LIMIT = 2000;          // Tests need a few hundred

  logic        dbg_clk;
  logic        dbg_rst;
  dbg_req_t    dbg_req;
  dbg_word_t   dbg_dout;
  logic        dbg_rd_rdy;
  logic        cpu_en_s;
  logic        dbg_en_s;
  logic        dbg_halt_st;
  logic        puc_pnd_set;
  logic        decode_noirq;
  dbg_word_t   fe_mdb_in;
  dbg_word_t   dbg_mem_din;
  dbg_word_t   dbg_reg_din;
  mem_bus_t    dbg_bus;
  logic        dbg_halt_cmd;
  logic        dbg_freeze;
  logic        dbg_cpu_reset;
  dbg_word_t   mem_model [256];                        // Word array
  dbg_word_t   reg_model [16];                         // CPU register file
  logic [31:0] lfsr_state;
  int          cycle_cnt;
  int          err_cnt;

  dbg_unit #(
    .SWBRK_OP   (BRK_OP),
    .RST_BRK_EN (RST_BRK)
  ) dbg_unit_i (
    .dbg_clk       (dbg_clk),
    .dbg_rst       (dbg_rst),
    .dbg_req       (dbg_req),
    .dbg_dout      (dbg_dout),
    .dbg_rd_rdy    (dbg_rd_rdy),
    .cpu_id        (CPU_ID),
    .cpu_en_s      (cpu_en_s),
    .dbg_en_s      (dbg_en_s),
    .dbg_halt_st   (dbg_halt_st),
    .puc_pnd_set   (puc_pnd_set),
    .decode_noirq  (decode_noirq),
    .fe_mdb_in     (fe_mdb_in),
    .dbg_mem_din   (dbg_mem_din),
    .dbg_reg_din   (dbg_reg_din),
    .dbg_bus       (dbg_bus),
    .dbg_halt_cmd  (dbg_halt_cmd),
    .dbg_freeze    (dbg_freeze),
    .dbg_cpu_reset (dbg_cpu_reset)
  );

  // ----------------------------------------
  // CPU, memory and register models
  // ----------------------------------------
  always @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_halt_st <= 1'b0;
    end else begin
      dbg_halt_st <= dbg_halt_cmd;                     // Halts one cycle late
    end
  end

  always @(posedge dbg_clk) begin
    if (dbg_bus.mem_en) begin
      if (dbg_bus.mem_wr[0]) begin
        mem_model[dbg_bus.addr[8:1]][7:0] <= dbg_bus.dout[7:0];
      end
      if (dbg_bus.mem_wr[1]) begin
        mem_model[dbg_bus.addr[8:1]][15:8] <= dbg_bus.dout[15:8];
      end
      dbg_mem_din <= mem_model[dbg_bus.addr[8:1]];     // Read data next cycle
    end
    if (dbg_bus.reg_wr) begin
      reg_model[dbg_bus.addr[3:0]] <= dbg_bus.dout;
    end
  end

  assign dbg_reg_din = reg_model[dbg_bus.addr[3:0]];  // Answers at once

  initial begin
    dbg_clk = 1'b0;
    forever #4 dbg_clk = ~dbg_clk;                     // 8 ns period
  end

  // Run limit
  always @(posedge dbg_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
      end_in_failure();
    end
  end

  // ----------------------------------------
  // Random data and checks
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form
  endfunction

  task automatic rand_bits(input int n, output dbg_word_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);              // One step per bit
      w[i] = lfsr_state[0];
    end
  endtask

  task automatic end_in_failure();
    err_cnt = err_cnt + 1;
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string name, input dbg_word_t got, input dbg_word_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s got %h expected %h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s got %b expected %b", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_bus(input string name, input mem_bus_t got, input mem_bus_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s got %h expected %h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  // ----------------------------------------
  // Host port access
  // ----------------------------------------
  task automatic write_strobe(input dbg_addr_t a, input dbg_word_t d);
    @(posedge dbg_clk);
    dbg_req <= {a, d, 1'b1, 1'b0};
  endtask

  task automatic end_strobe();
    @(posedge dbg_clk);
    dbg_req.wr <= 1'b0;                                // Write lands on this edge
  endtask

  task automatic host_write(input dbg_addr_t a, input dbg_word_t d);
    write_strobe(a, d);
    end_strobe();
  endtask

  task automatic host_read(input dbg_addr_t a, output dbg_word_t d);
    @(posedge dbg_clk);
    dbg_req <= {a, 16'h0000, 1'b0, 1'b1};
    @(negedge dbg_clk);
    d = dbg_dout;
    check_bit("dbg_rd_rdy", dbg_rd_rdy, 1'b0);
    @(posedge dbg_clk);
    dbg_req.rd <= 1'b0;
    @(negedge dbg_clk);
    check_bit("dbg_rd_rdy", dbg_rd_rdy, 1'b1);         // One cycle after rd
  endtask

  task automatic wait_halt_st(input logic v);
    @(negedge dbg_clk);
    while (dbg_halt_st !== v) begin
      @(negedge dbg_clk);                              // Bounded by the run limit
    end
  endtask

  `include "dbg_tests.svh"

  initial begin
    dbg_rst      = 1'b1;
    dbg_req      = '0;
    cpu_en_s     = 1'b1;
    dbg_en_s     = 1'b1;
    dbg_halt_st  = 1'b0;
    puc_pnd_set  = 1'b0;
    decode_noirq = 1'b0;
    fe_mdb_in    = '0;
    dbg_mem_din  = '0;
    lfsr_state   = SEED;
    cycle_cnt    = 0;
    err_cnt      = 0;
    for (int i = 0; i < 256; i++) begin
      mem_model[i] = {i[7:0] ^ 8'ha5, ~i[7:0]};
    end
    for (int i = 0; i < 16; i++) begin
      reg_model[i] = {i[3:0], 4'hc, ~i[3:0], 4'h3};
    end
    repeat (5) @(posedge dbg_clk);
    dbg_rst <= 1'b0;
    after_reset();
    halt_and_run();
    single_step();
    software_break();
    access_while_halted();
    access_while_running();
    @(posedge dbg_clk);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
hdl/dbg_pkg.sv
hdl/dbg_reg_port.sv
hdl/dbg_cpu_ctl.sv
hdl/dbg_mem_access.sv
hdl/dbg_unit.sv
verification/tb_dbg_unit.sv
